/* design/branch_pkg.sv */
`default_nettype none

package branch_pkg;

    // Broadcast carried on the resolve bus
    typedef enum logic [1:0] {
        task_nothing = 2'b00,
        task_clear   = 2'b01, // Prediction held, tag retires
        task_squash  = 2'b10  // Mispredict, tag and younger ones die
    } br_task_e;

    // Kind of control transfer being resolved
    typedef enum logic [1:0] {
        kind_cond = 2'b00,
        kind_jal  = 2'b01,
        kind_jalr = 2'b10
    } br_kind_e;

    // RV32I B-type funct3
    parameter logic [2:0] funct3_beq  = 3'b000;
    parameter logic [2:0] funct3_bne  = 3'b001;
    parameter logic [2:0] funct3_blt  = 3'b100;
    parameter logic [2:0] funct3_bge  = 3'b101;
    parameter logic [2:0] funct3_bltu = 3'b110;
    parameter logic [2:0] funct3_bgeu = 3'b111;

endpackage

`default_nettype wire

/* design/branch_target_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_target_adder #(
    parameter int xlen = 32
) (
    input  logic                 [xlen-1:0] pc,
    input  logic                 [xlen-1:0] imm,
    input  logic                 [xlen-1:0] rs1_value,
    input  branch_pkg::br_kind_e            kind,
    output logic                 [xlen-1:0] target
);

    logic [xlen-1:0] base;
    logic [xlen-1:0] sum;
    logic            is_jalr;

    assign is_jalr = (kind == branch_pkg::kind_jalr);

    // JALR is register relative, the rest are PC relative
    assign base = is_jalr ? rs1_value : pc;

    assign sum = base + imm;

    always_comb begin
        if (is_jalr) begin
            target = {sum[xlen-1:1], 1'b0}; // LSB forced low per ISA
        end else begin
            target = sum;
        end
    end

endmodule

`default_nettype wire

/* design/branch_condition.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_condition #(
    parameter int xlen = 32
) (
    input  logic                 [xlen-1:0] rs1_value,
    input  logic                 [xlen-1:0] rs2_value,
    input  logic                 [2:0]      funct3,
    input  branch_pkg::br_kind_e            kind,
    output logic                            taken
);

    logic cond_taken;
    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rs1_value == rs2_value);
    assign lt_s = ($signed(rs1_value) < $signed(rs2_value));
    assign lt_u = (rs1_value < rs2_value);

    always_comb begin
        case (funct3)
            branch_pkg::funct3_beq:  cond_taken = eq;
            branch_pkg::funct3_bne:  cond_taken = !eq;
            branch_pkg::funct3_blt:  cond_taken = lt_s;
            branch_pkg::funct3_bge:  cond_taken = !lt_s;
            branch_pkg::funct3_bltu: cond_taken = lt_u;
            branch_pkg::funct3_bgeu: cond_taken = !lt_u;
            default:                 cond_taken = 1'b0; // Reserved encodings never branch
        endcase
    end

    // Jumps are always taken
    always_comb begin
        if (kind == branch_pkg::kind_cond) begin
            taken = cond_taken;
        end else begin
            taken = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/branch_fu.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_fu #(
    parameter int xlen     = 32,
    parameter int num_tags = 4
) (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            issue_valid,
    input  logic                 [xlen-1:0] issue_pc,
    input  logic                 [xlen-1:0] issue_npc,
    input  logic                 [xlen-1:0] issue_imm,
    input  logic                 [xlen-1:0] rs1_value,
    input  logic                 [xlen-1:0] rs2_value,
    input  logic                 [2:0]      funct3,
    input  branch_pkg::br_kind_e            kind,
    input  logic                            pred_taken,
    input  logic                 [xlen-1:0] pred_target,
    input  logic             [num_tags-1:0] issue_b_id,
    input  logic             [num_tags-1:0] issue_b_mask,
    input  branch_pkg::br_task_e            rem_task,
    input  logic             [num_tags-1:0] rem_b_id,
    output logic                            resolve_valid,
    output branch_pkg::br_task_e            resolve_task,
    output logic             [num_tags-1:0] resolve_b_id,
    output logic             [num_tags-1:0] resolve_b_mask,
    output logic                 [xlen-1:0] resolve_target,
    output logic                 [xlen-1:0] resolve_link,
    output logic                            pred_correct,
    output logic                            br_taken
);

    logic [xlen-1:0]     taken_target;
    logic [xlen-1:0]     next_target;
    logic                taken;
    logic                correct;
    logic                killed;
    logic                fire;
    logic [num_tags-1:0] mask_upd;

    branch_target_adder #(
        .xlen(xlen)
    ) i_branch_target_adder (
        .pc        (issue_pc),
        .imm       (issue_imm),
        .rs1_value (rs1_value),
        .kind      (kind),
        .target    (taken_target)
    );

    branch_condition #(
        .xlen(xlen)
    ) i_branch_condition (
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .funct3    (funct3),
        .kind      (kind),
        .taken     (taken)
    );

    assign next_target = taken ? taken_target : issue_npc;

    // Direction must match, and the address too when taken
    assign correct = (pred_taken == taken) && (!taken || (pred_target == taken_target));

    // Issue under a branch that is being squashed right now
    assign killed = (rem_task == branch_pkg::task_squash) && ((issue_b_mask & rem_b_id) != '0);
    assign fire   = issue_valid && !killed;

    always_comb begin
        if (rem_task == branch_pkg::task_clear) begin
            mask_upd = issue_b_mask & ~rem_b_id; // Resolved dependency drops out
        end else begin
            mask_upd = issue_b_mask;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n || !fire) begin
            resolve_valid  <= 1'b0;
            resolve_task   <= branch_pkg::task_nothing;
            resolve_b_id   <= '0;
            resolve_b_mask <= '0;
            resolve_target <= '0;
            resolve_link   <= '0;
            pred_correct   <= 1'b0;
            br_taken       <= 1'b0;
        end else begin
            resolve_valid  <= 1'b1;
            resolve_task   <= correct ? branch_pkg::task_clear : branch_pkg::task_squash;
            resolve_b_id   <= issue_b_id;
            resolve_b_mask <= mask_upd;
            resolve_target <= next_target;
            resolve_link   <= issue_npc; // Return address for JAL/JALR
            pred_correct   <= correct;
            br_taken       <= taken;
        end
    end

endmodule

`default_nettype wire

/* design/branch_tag_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_tag_tracker #(
    parameter int num_tags = 4
) (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            alloc_req,
    input  branch_pkg::br_task_e            rem_task,
    input  logic             [num_tags-1:0] rem_b_id,
    output logic             [num_tags-1:0] alloc_id,
    output logic             [num_tags-1:0] alloc_mask,
    output logic             [num_tags-1:0] busy_tags,
    output logic                            tags_full
);

    logic [num_tags-1:0] busy;
    logic [num_tags-1:0] dep_mask [num_tags];
    logic [num_tags-1:0] kill;
    logic [num_tags-1:0] busy_after;
    logic                is_clear;
    logic                is_squash;
    logic                do_alloc;

    assign is_clear  = (rem_task == branch_pkg::task_clear);
    assign is_squash = (rem_task == branch_pkg::task_squash);

    assign busy_tags = busy;
    assign tags_full = &busy;

    // Lowest zero bit, all zeros once every tag is taken
    assign alloc_id = ~busy & (busy + 1'b1);

    assign alloc_mask = is_clear ? (busy & ~rem_b_id) : busy;

    assign do_alloc = alloc_req && !is_squash && !tags_full;

    // Squashed tag plus every live tag that depends on it
    always_comb begin
        for (int i = 0; i < num_tags; i++) begin
            kill[i] = rem_b_id[i] || (busy[i] && ((dep_mask[i] & rem_b_id) != '0));
        end
    end

    always_comb begin
        if (is_squash) begin
            busy_after = busy & ~kill;
        end else if (is_clear) begin
            busy_after = busy & ~rem_b_id;
        end else begin
            busy_after = busy;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            busy <= do_alloc ? (busy_after | alloc_id) : busy_after;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < num_tags; i++) begin
            if (do_alloc && alloc_id[i]) begin
                dep_mask[i] <= alloc_mask; // Older branches this one sits under
            end else if (is_clear) begin
                dep_mask[i] <= dep_mask[i] & ~rem_b_id;
            end
        end
    end

endmodule

`default_nettype wire

/* design/branch_resolve_top.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_resolve_top #(
    parameter int xlen     = 32,
    parameter int num_tags = 4
) (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            alloc_req,
    input  logic                            issue_valid,
    input  logic                 [xlen-1:0] issue_pc,
    input  logic                 [xlen-1:0] issue_npc,
    input  logic                 [xlen-1:0] issue_imm,
    input  logic                 [xlen-1:0] rs1_value,
    input  logic                 [xlen-1:0] rs2_value,
    input  logic                 [2:0]      funct3,
    input  branch_pkg::br_kind_e            kind,
    input  logic                            pred_taken,
    input  logic                 [xlen-1:0] pred_target,
    input  logic             [num_tags-1:0] issue_b_id,
    input  logic             [num_tags-1:0] issue_b_mask,
    output logic             [num_tags-1:0] alloc_id,
    output logic             [num_tags-1:0] alloc_mask,
    output logic             [num_tags-1:0] busy_tags,
    output logic                            tags_full,
    output logic                            resolve_valid,
    output branch_pkg::br_task_e            resolve_task,
    output logic             [num_tags-1:0] resolve_b_id,
    output logic             [num_tags-1:0] resolve_b_mask,
    output logic                 [xlen-1:0] resolve_target,
    output logic                 [xlen-1:0] resolve_link,
    output logic                            pred_correct,
    output logic                            br_taken
);

    branch_fu #(
        .xlen     (xlen),
        .num_tags (num_tags)
    ) i_branch_fu (
        .clock          (clock),
        .rst_n          (rst_n),
        .issue_valid    (issue_valid),
        .issue_pc       (issue_pc),
        .issue_npc      (issue_npc),
        .issue_imm      (issue_imm),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .funct3         (funct3),
        .kind           (kind),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target),
        .issue_b_id     (issue_b_id),
        .issue_b_mask   (issue_b_mask),
        .rem_task       (resolve_task), // Registered broadcast loops back
        .rem_b_id       (resolve_b_id),
        .resolve_valid  (resolve_valid),
        .resolve_task   (resolve_task),
        .resolve_b_id   (resolve_b_id),
        .resolve_b_mask (resolve_b_mask),
        .resolve_target (resolve_target),
        .resolve_link   (resolve_link),
        .pred_correct   (pred_correct),
        .br_taken       (br_taken)
    );

    branch_tag_tracker #(
        .num_tags (num_tags)
    ) i_branch_tag_tracker (
        .clock      (clock),
        .rst_n      (rst_n),
        .alloc_req  (alloc_req),
        .rem_task   (resolve_task),
        .rem_b_id   (resolve_b_id),
        .alloc_id   (alloc_id),
        .alloc_mask (alloc_mask),
        .busy_tags  (busy_tags),
        .tags_full  (tags_full)
    );

endmodule

`default_nettype wire

/* testbench/branch_tests.svh */
task automatic apply_reset();
    rst_n       = 1'b0;
    alloc_req   = 1'b0;
    issue_valid = 1'b0;
    repeat (3) @(negedge clock);
    rst_n = 1'b1;
endtask

task automatic drive_issue(input branch_pkg::br_kind_e k, input logic [2:0] f3,
                           input logic [31:0] pc, input logic [31:0] imm,
                           input logic [31:0] a, input logic [31:0] b,
                           input logic p_taken, input logic [31:0] p_target,
                           input logic [3:0] id, input logic [3:0] mask);
    kind         = k;
    funct3       = f3;
    issue_pc     = pc;
    issue_npc    = pc + 32'd4;
    issue_imm    = imm;
    rs1_value    = a;
    rs2_value    = b;
    pred_taken   = p_taken;
    pred_target  = p_target;
    issue_b_id   = id;
    issue_b_mask = mask;
    issue_valid  = 1'b1;
endtask

// Returns on the falling edge where the broadcast is visible
task automatic wait_resolve(output bit seen, input int limit);
    seen = 1'b0;
    for (int n = 0; n < limit && !seen; n++) begin
        @(negedge clock);
        issue_valid = 1'b0;
        alloc_req   = 1'b0;
        if (resolve_valid) begin
            seen = 1'b1;
        end
    end
endtask

task automatic run_branch(input branch_pkg::br_kind_e k, input logic [2:0] f3,
                          input logic [31:0] pc, input logic [31:0] imm,
                          input logic [31:0] a, input logic [31:0] b,
                          input logic p_taken, input logic [31:0] p_target,
                          input logic [3:0] id, input logic [3:0] mask,
                          input logic [3:0] exp_mask);
    logic        exp_taken;
    logic [31:0] exp_target;
    logic        exp_correct;
    bit          seen;
    exp_taken   = ref_taken(k, f3, a, b);
    exp_target  = ref_target(k, pc, imm, a);
    exp_correct = prediction_correct(p_taken, p_target, exp_taken, exp_target);
    drive_issue(k, f3, pc, imm, a, b, p_taken, p_target, id, mask);
    wait_resolve(seen, 5);
    if (!seen) begin
        errors++;
        $display("Timeout: branch with id %b never produced a resolve", id);
    end else begin
        check_value("br_taken", 32'(br_taken), 32'(exp_taken));
        check_value("resolve_target", resolve_target, exp_taken ? exp_target : pc + 32'd4);
        check_value("resolve_link", resolve_link, pc + 32'd4);
        check_value("pred_correct", 32'(pred_correct), 32'(exp_correct));
        check_value("resolve_task", 32'(resolve_task),
                    exp_correct ? 32'(branch_pkg::task_clear) : 32'(branch_pkg::task_squash));
        check_value("resolve_b_id", 32'(resolve_b_id), 32'(id));
        check_value("resolve_b_mask", 32'(resolve_b_mask), 32'(exp_mask));
    end
endtask

// Taken beq where the prediction decides clear or squash
task automatic resolve_tag(input logic [3:0] id, input logic [3:0] mask,
                           input logic [3:0] exp_mask, input logic predict_ok);
    run_branch(branch_pkg::kind_cond, branch_pkg::funct3_beq, 32'h0000_4000, 32'h40,
               32'h55, 32'h55, predict_ok, 32'h0000_4040, id, mask, exp_mask);
endtask

task automatic alloc_tags(input int count);
    for (int k = 0; k < count; k++) begin
        alloc_req = 1'b1;
        @(negedge clock);
        alloc_req = 1'b0;
    end
endtask

task automatic test_reset_state();
    check_value("resolve_valid", 32'(resolve_valid), 0);
    check_value("resolve_task", 32'(resolve_task), 32'(branch_pkg::task_nothing));
    check_value("busy_tags", 32'(busy_tags), 0);
    check_value("tags_full", 32'(tags_full), 0);
endtask

task automatic test_conditional();
    logic [2:0]  codes [6];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc;
    logic [31:0] imm;
    codes[0] = branch_pkg::funct3_beq;
    codes[1] = branch_pkg::funct3_bne;
    codes[2] = branch_pkg::funct3_blt;
    codes[3] = branch_pkg::funct3_bge;
    codes[4] = branch_pkg::funct3_bltu;
    codes[5] = branch_pkg::funct3_bgeu;
    for (int c = 0; c < 6; c++) begin
        for (int p = 0; p < 4; p++) begin
            case (p)
                0: begin
                    a = $urandom; // Equal operands
                    b = a;
                end
                1: begin
                    a = $urandom | 32'h8000_0000;
                    b = $urandom & 32'h7fff_ffff;
                end
                2: begin
                    a = $urandom & 32'h7fff_ffff;
                    b = $urandom | 32'h8000_0000;
                end
                default: begin
                    a = $urandom;
                    b = $urandom;
                end
            endcase
            pc  = $urandom & 32'hffff_fffc;
            imm = ($urandom & 32'h0000_1ffe) - 32'h0000_1000;
            for (int pr = 0; pr < 2; pr++) begin
                run_branch(branch_pkg::kind_cond, codes[c], pc, imm, a, b, pr[0],
                           ref_target(branch_pkg::kind_cond, pc, imm, a), 4'b0001, 4'b0000,
                           4'b0000);
            end
        end
    end
    // Reserved funct3 never branches
    run_branch(branch_pkg::kind_cond, 3'b010, 32'h100, 32'h20, 32'h7, 32'h7, 1'b0, 32'h120,
               4'b0001, 4'b0000, 4'b0000);
endtask

task automatic test_unconditional();
    logic [31:0] pc;
    logic [31:0] imm;
    logic [31:0] a;
    pc  = $urandom & 32'hffff_fffc;
    imm = ($urandom & 32'h000f_fffe) - 32'h0008_0000;
    a   = $urandom;
    run_branch(branch_pkg::kind_jal, 3'b000, pc, imm, a, 32'h0, 1'b1,
               pc + imm, 4'b0010, 4'b0000, 4'b0000);
    run_branch(branch_pkg::kind_jalr, 3'b000, pc, 32'h10, 32'h1000_0003, 32'h0, 1'b1,
               32'h1000_0012, 4'b0010, 4'b0000, 4'b0000);
    run_branch(branch_pkg::kind_jal, 3'b000, pc, imm, a, 32'h0, 1'b1,
               pc + imm + 32'd8, 4'b0100, 4'b0000, 4'b0000); // Wrong address
    run_branch(branch_pkg::kind_jalr, 3'b000, pc, imm, a, 32'h0, 1'b0,
               32'h0, 4'b0100, 4'b0000, 4'b0000);
endtask

task automatic test_tag_alloc();
    apply_reset();
    for (int k = 0; k < 4; k++) begin
        check_value("alloc_id", 32'(alloc_id), 32'(1) << k);
        check_value("alloc_mask", 32'(alloc_mask), (32'(1) << k) - 32'd1);
        check_value("tags_full", 32'(tags_full), 0);
        alloc_tags(1);
    end
    check_value("busy_tags", 32'(busy_tags), 32'h0000_000f);
    check_value("tags_full", 32'(tags_full), 1);
    check_value("alloc_id", 32'(alloc_id), 0);
    resolve_tag(4'b0010, 4'b0001, 4'b0001, 1'b1);
    check_value("alloc_mask", 32'(alloc_mask), 32'h0000_000d); // Clear seen in same cycle
    @(negedge clock);
    check_value("busy_tags", 32'(busy_tags), 32'h0000_000d);
    check_value("tags_full", 32'(tags_full), 0);
    check_value("alloc_id", 32'(alloc_id), 32'h0000_0002);
endtask

task automatic test_mask_clear();
    apply_reset();
    alloc_tags(4);
    resolve_tag(4'b0001, 4'b0000, 4'b0000, 1'b1);
    resolve_tag(4'b0100, 4'b0011, 4'b0010, 1'b1); // Issued under the tag 0 clear
    @(negedge clock);
    check_value("busy_tags", 32'(busy_tags), 32'h0000_000a);
endtask

task automatic test_squash();
    bit seen;
    apply_reset();
    alloc_tags(3); // Tag 3 stays free for the ignored request
    resolve_tag(4'b0010, 4'b0001, 4'b0001, 1'b0);
    drive_issue(branch_pkg::kind_cond, branch_pkg::funct3_bne, 32'h200, 32'h8, 32'h1, 32'h2,
                1'b1, 32'h208, 4'b0100, 4'b0011);
    alloc_req = 1'b1; // Must be ignored while squashing
    wait_resolve(seen, 4);
    if (seen) begin
        errors++;
        $display("Error: branch issued under a squashed tag still produced a resolve");
    end
    check_value("busy_tags", 32'(busy_tags), 32'h0000_0001);
    check_value("tags_full", 32'(tags_full), 0);
    check_value("alloc_id", 32'(alloc_id), 32'h0000_0002);
endtask

/* testbench/branch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_tb;

    localparam int xlen     = 32;
    localparam int num_tags = 4;

    logic                 clock;
    logic                 rst_n;
    logic                 alloc_req;
    logic                 issue_valid;
    logic [xlen-1:0]      issue_pc;
    logic [xlen-1:0]      issue_npc;
    logic [xlen-1:0]      issue_imm;
    logic [xlen-1:0]      rs1_value;
    logic [xlen-1:0]      rs2_value;
    logic [2:0]           funct3;
    branch_pkg::br_kind_e kind;
    logic                 pred_taken;
    logic [xlen-1:0]      pred_target;
    logic [num_tags-1:0]  issue_b_id;
    logic [num_tags-1:0]  issue_b_mask;
    logic [num_tags-1:0]  alloc_id;
    logic [num_tags-1:0]  alloc_mask;
    logic [num_tags-1:0]  busy_tags;
    logic                 tags_full;
    logic                 resolve_valid;
    branch_pkg::br_task_e resolve_task;
    logic [num_tags-1:0]  resolve_b_id;
    logic [num_tags-1:0]  resolve_b_mask;
    logic [xlen-1:0]      resolve_target;
    logic [xlen-1:0]      resolve_link;
    logic                 pred_correct;
    logic                 br_taken;

    int checks = 0;
    int errors = 0;

    branch_resolve_top #(
        .xlen     (xlen),
        .num_tags (num_tags)
    ) i_branch_resolve_top (
        .clock          (clock),
        .rst_n          (rst_n),
        .alloc_req      (alloc_req),
        .issue_valid    (issue_valid),
        .issue_pc       (issue_pc),
        .issue_npc      (issue_npc),
        .issue_imm      (issue_imm),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .funct3         (funct3),
        .kind           (kind),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target),
        .issue_b_id     (issue_b_id),
        .issue_b_mask   (issue_b_mask),
        .alloc_id       (alloc_id),
        .alloc_mask     (alloc_mask),
        .busy_tags      (busy_tags),
        .tags_full      (tags_full),
        .resolve_valid  (resolve_valid),
        .resolve_task   (resolve_task),
        .resolve_b_id   (resolve_b_id),
        .resolve_b_mask (resolve_b_mask),
        .resolve_target (resolve_target),
        .resolve_link   (resolve_link),
        .pred_correct   (pred_correct),
        .br_taken       (br_taken)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // Signed order taken from the sign bits
    function automatic logic ref_taken(input branch_pkg::br_kind_e k, input logic [2:0] f3,
                                       input logic [31:0] a, input logic [31:0] b);
        logic less_s;
        logic result;
        less_s = (a[31] != b[31]) ? a[31] : (a < b);
        case (f3)
            branch_pkg::funct3_beq:  result = (a == b);
            branch_pkg::funct3_bne:  result = (a != b);
            branch_pkg::funct3_blt:  result = less_s;
            branch_pkg::funct3_bge:  result = !less_s;
            branch_pkg::funct3_bltu: result = (a < b);
            branch_pkg::funct3_bgeu: result = (a >= b);
            default:                 result = 1'b0;
        endcase
        if (k != branch_pkg::kind_cond) begin
            result = 1'b1;
        end
        return result;
    endfunction

    function automatic logic [31:0] ref_target(input branch_pkg::br_kind_e k,
                                               input logic [31:0] pc, input logic [31:0] imm,
                                               input logic [31:0] a);
        if (k == branch_pkg::kind_jalr) begin
            return (a + imm) & 32'hffff_fffe;
        end
        return pc + imm;
    endfunction

    // Target only matters once the direction agrees on taken
    function automatic logic prediction_correct(input logic p_taken,
                                                input logic [31:0] p_target,
                                                input logic taken,
                                                input logic [31:0] target);
        if (p_taken != taken) begin
            return 1'b0;
        end
        if (taken) begin
            return p_target == target;
        end
        return 1'b1;
    endfunction

    `include "branch_tests.svh"

    initial begin
        rst_n        = 1'b0;
        alloc_req    = 1'b0;
        issue_valid  = 1'b0;
        issue_pc     = '0;
        issue_npc    = '0;
        issue_imm    = '0;
        rs1_value    = '0;
        rs2_value    = '0;
        funct3       = '0;
        kind         = branch_pkg::kind_cond;
        pred_taken   = 1'b0;
        pred_target  = '0;
        issue_b_id   = '0;
        issue_b_mask = '0;
        void'($urandom(32'h3078fdb2));
        apply_reset();
        test_reset_state();
        test_conditional();
        test_unconditional();
        test_tag_alloc();
        test_mask_clear();
        test_squash();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
design/branch_pkg.sv
design/branch_target_adder.sv
design/branch_condition.sv
design/branch_fu.sv
design/branch_tag_tracker.sv
design/branch_resolve_top.sv
+incdir+testbench
testbench/branch_tb.sv

/* Makefile */
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module branch_tb

sim:
	verilator --binary --timing -f sources.f --top-module branch_tb -Mdir obj_dir
	./obj_dir/Vbranch_tb | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
